// ==== Makefile ====
TOOL       = verilator
TOP        = pwm_io_tb
FILELIST   = pwm_io_top.f
OBJ_DIR    = obj_dir
LINT_FLAGS = --lint-only --timing --assert
SIM_FLAGS  = --binary --timing --assert -j 0
PASS_MSG   = TESTBENCH PASSED

.PHONY: all lint sim clean

all: sim

# Static checks on the whole project
lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

# Build and run, pass only if the pass line shows up in the output
sim:
	$(TOOL) $(SIM_FLAGS) --Mdir $(OBJ_DIR) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== pwm_io_top.f ====
rtl/pwm_io_pkg.sv
rtl/ebus_frontend.sv
rtl/pwm_channel.sv
rtl/ebus_readback.sv
rtl/pwm_io_top.sv
testbench/pwm_io_checker.sv
testbench/pwm_io_tb.sv

// ==== rtl/ebus_frontend.sv ====
module ebus_frontend #(
    parameter int         NUM_CHANNELS = 4,
    parameter logic [7:0] BASE_PORT    = 8'hE0
) (
    input  logic                 clk,
    input  logic                 reset,

    // Z80 bus
    input  logic [15:0]          a,
    input  logic [7:0]           d_in,
    input  logic                 rd_n,
    input  logic                 wr_n,
    input  logic                 iorq_n,

    // Decoded request and end of read
    output pwm_io_pkg::bus_req_t req,
    output logic                 rd_done
);

    import pwm_io_pkg::*;

    logic [2:0] rd_q;
    logic [2:0] wr_q;
    logic       rd_fall;
    logic       rd_rise;
    logic       wr_fall;
    logic       wr_rise;
    fe_state_e  state;
    logic [7:0] port;
    logic [7:0] offset;
    logic [8:0] port_end;
    logic       port_hit;
    bus_req_t   next_pend;
    bus_req_t   pend;

    ////////////////////////////////////////////////////////////
    // Strobe synchronizers and edge detect
    ////////////////////////////////////////////////////////////

    // Strobes idle high, so reset fills with ones
    always_ff @(posedge clk) begin
        if (reset) begin
            rd_q <= 3'b111;
            wr_q <= 3'b111;
        end else begin
            rd_q <= {rd_q[1:0], rd_n};
            wr_q <= {wr_q[1:0], wr_n};
        end
    end

    assign rd_fall = rd_q[2:1] == 2'b10;
    assign rd_rise = rd_q[2:1] == 2'b01;
    assign wr_fall = wr_q[2:1] == 2'b10;
    assign wr_rise = wr_q[2:1] == 2'b01;

    // Bus cycle tracking
    always_ff @(posedge clk) begin
        if (reset) begin
            state <= FE_IDLE;
        end else if (rd_fall) begin
            state <= FE_READ;
        end else if (wr_fall) begin
            state <= FE_WRITE;
        end else if ((state == FE_READ && rd_rise) || (state == FE_WRITE && wr_rise)) begin
            state <= FE_IDLE;
        end
    end

    ////////////////////////////////////////////////////////////
    // Port decode
    ////////////////////////////////////////////////////////////

    // Only the low address byte counts on Z80 I/O
    assign port     = a[7:0];
    assign offset   = port - BASE_PORT;
    assign port_end = {1'b0, BASE_PORT} + 9'(2 * NUM_CHANNELS);
    assign port_hit = (port >= BASE_PORT) && ({1'b0, port} < port_end);

    // Address, data and iorq_n are already stable at the edge
    always_comb begin
        next_pend.valid = (rd_fall || wr_fall) && !iorq_n && port_hit;
        next_pend.write = wr_fall;
        next_pend.chan  = offset[CHAN_W:1];
        next_pend.sel   = reg_sel_e'(offset[0]);
        next_pend.data  = d_in;
    end

    // Two stages: capture at the edge, then issue
    always_ff @(posedge clk) begin
        if (reset) begin
            pend.valid <= 1'b0;
            req.valid  <= 1'b0;
            rd_done    <= 1'b0;
        end else begin
            pend    <= next_pend;
            req     <= pend;
            rd_done <= rd_rise && state == FE_READ;
        end
    end

endmodule

// ==== rtl/ebus_readback.sv ====
module ebus_readback #(
    parameter int NUM_CHANNELS = 4
) (
    input  logic                                      clk,
    input  logic                                      reset,

    // Front end request and end of read
    input  pwm_io_pkg::bus_req_t                      req,
    input  logic                                      rd_done,

    // Channel registers
    input  pwm_io_pkg::chan_regs_t [NUM_CHANNELS-1:0] regs,

    // Data bus drive
    output logic [7:0]                                d_out,
    output logic                                      d_oe
);

    import pwm_io_pkg::*;

    chan_regs_t        sel_regs;
    logic [DATA_W-1:0] rd_data;
    logic              rd_req;

    assign rd_req = req.valid && !req.write;

    // Channel mux, then register format
    always_comb begin
        sel_regs = '0;
        for (int k = 0; k < NUM_CHANNELS; k++) begin
            if (req.chan == CHAN_W'(k)) begin
                sel_regs = regs[k];
            end
        end
        if (req.sel == REG_CTRL) begin
            rd_data = {{(DATA_W - 1){1'b0}}, sel_regs.enable};
        end else begin
            rd_data = sel_regs.sample;
        end
    end

    // Data held on the bus until rd_n goes back high
    always_ff @(posedge clk) begin
        if (reset) begin
            d_out <= '0;
            d_oe  <= 1'b0;
        end else if (rd_req) begin
            d_out <= rd_data;
            d_oe  <= 1'b1;
        end else if (rd_done) begin
            d_out <= '0;
            d_oe  <= 1'b0;
        end
    end

endmodule

// ==== rtl/pwm_channel.sv ====
module pwm_channel #(
    parameter int CHAN_INDEX = 0
) (
    input  logic                   clk,
    input  logic                   reset,

    // Request from the bus front end
    input  pwm_io_pkg::bus_req_t   req,

    // Register contents for readback
    output pwm_io_pkg::chan_regs_t regs,

    // PWM audio bit
    output logic                   pwm
);

    import pwm_io_pkg::*;

    logic [DATA_W-1:0] count;
    logic              wr_hit;

    ////////////////////////////////////////////////////////////
    // Register writes
    ////////////////////////////////////////////////////////////

    // Writes addressed to this channel only
    assign wr_hit = req.valid && req.write && (req.chan == CHAN_W'(CHAN_INDEX));

    always_ff @(posedge clk) begin
        if (reset) begin
            regs <= '0;
        end else if (wr_hit) begin
            case (req.sel)
                REG_SAMPLE: begin
                    regs.sample <= req.data;
                end
                REG_CTRL: begin
                    // Enable lives in data bit 0
                    regs.enable <= req.data[0];
                end
            endcase
        end
    end

    ////////////////////////////////////////////////////////////
    // PWM generation
    ////////////////////////////////////////////////////////////

    // Free running counter wraps every 256 cycles
    always_ff @(posedge clk) begin
        if (reset) begin
            count <= '0;
        end else begin
            count <= count + 1'b1;
        end
    end

    // High for exactly sample cycles out of each period
    assign pwm = regs.enable && (count < regs.sample);

endmodule

// ==== rtl/pwm_io_pkg.sv ====
package pwm_io_pkg;

    ////////////////////////////////////////////////////////////
    // Widths
    ////////////////////////////////////////////////////////////

    // Channel index, enough for up to 4 channels
    localparam int CHAN_W = 2;

    // Z80 data bus and sample width
    localparam int DATA_W = 8;

    ////////////////////////////////////////////////////////////
    // Enums
    ////////////////////////////////////////////////////////////

    // Register inside a channel, taken from port bit 0
    typedef enum logic [0:0] {
        REG_SAMPLE = 1'b0,
        REG_CTRL   = 1'b1
    } reg_sel_e;

    // Bus cycle currently seen by the front end
    typedef enum logic [1:0] {
        FE_IDLE  = 2'd0,
        FE_READ  = 2'd1,
        FE_WRITE = 2'd2
    } fe_state_e;

    ////////////////////////////////////////////////////////////
    // Structs
    ////////////////////////////////////////////////////////////

    // One decoded I/O cycle, valid for a single clock
    typedef struct packed {
        logic              valid;
        logic              write;
        logic [CHAN_W-1:0] chan;
        reg_sel_e          sel;
        logic [DATA_W-1:0] data;
    } bus_req_t;

    // Register contents of one channel
    typedef struct packed {
        logic [DATA_W-1:0] sample;
        logic              enable;
    } chan_regs_t;

endpackage

// ==== rtl/pwm_io_top.sv ====
module pwm_io_top #(
    parameter int         NUM_CHANNELS = 4,
    parameter logic [7:0] BASE_PORT    = 8'hE0
) (
    input  logic                    clk,
    input  logic                    reset,

    // Z80 bus, split data lines
    input  logic [15:0]             a,
    input  logic [7:0]              d_in,
    output logic [7:0]              d_out,
    output logic                    d_oe,
    input  logic                    rd_n,
    input  logic                    wr_n,
    input  logic                    iorq_n,

    // PWM audio outputs
    output logic [NUM_CHANNELS-1:0] pwm_out
);

    import pwm_io_pkg::*;

    bus_req_t                    req;
    logic                        rd_done;
    chan_regs_t [NUM_CHANNELS-1:0] regs;

    ////////////////////////////////////////////////////////////
    // Bus front end
    ////////////////////////////////////////////////////////////
    ebus_frontend #(
        .NUM_CHANNELS(NUM_CHANNELS),
        .BASE_PORT(BASE_PORT)
    ) i_frontend (
        .clk(clk),
        .reset(reset),
        .a(a),
        .d_in(d_in),
        .rd_n(rd_n),
        .wr_n(wr_n),
        .iorq_n(iorq_n),
        .req(req),
        .rd_done(rd_done)
    );

    ////////////////////////////////////////////////////////////
    // PWM channels
    ////////////////////////////////////////////////////////////
    for (genvar k = 0; k < NUM_CHANNELS; k++) begin : g_chan
        pwm_channel #(
            .CHAN_INDEX(k)
        ) i_channel (
            .clk(clk),
            .reset(reset),
            .req(req),
            .regs(regs[k]),
            .pwm(pwm_out[k])
        );
    end

    ////////////////////////////////////////////////////////////
    // Register readback
    ////////////////////////////////////////////////////////////
    ebus_readback #(
        .NUM_CHANNELS(NUM_CHANNELS)
    ) i_readback (
        .clk(clk),
        .reset(reset),
        .req(req),
        .rd_done(rd_done),
        .regs(regs),
        .d_out(d_out),
        .d_oe(d_oe)
    );

endmodule

// ==== testbench/pwm_io_checker.sv ====
module pwm_io_checker #(
    parameter int NUM_CHANNELS = 4
) (
    input logic                                      clk,
    input logic                                      reset,
    input logic                                      rd_n,
    input logic                                      d_oe,
    input logic [NUM_CHANNELS-1:0]                   pwm_out,
    input pwm_io_pkg::bus_req_t                      req,
    input pwm_io_pkg::chan_regs_t [NUM_CHANNELS-1:0] regs,
    input pwm_io_pkg::fe_state_e                     fe_state
);

    import pwm_io_pkg::*;

    int                      fail_count = 0;
    logic [NUM_CHANNELS-1:0] enables;

    always_comb begin
        for (int k = 0; k < NUM_CHANNELS; k++) begin
            enables[k] = regs[k].enable;
        end
    end

    // No read data on the bus while a write cycle is in progress
    a_no_oe_in_write: assert property (@(posedge clk) disable iff (reset)
        !(d_oe && fe_state == FE_WRITE))
        else begin
            fail_count++;
            $error("d_oe high during a write cycle");
        end

    // Disabled channels stay silent
    a_pwm_gated: assert property (@(posedge clk) disable iff (reset)
        (pwm_out & ~enables) == '0)
        else begin
            fail_count++;
            $error("pwm_out high on a channel with enable clear");
        end

    // One request per bus cycle
    a_req_single: assert property (@(posedge clk) disable iff (reset)
        req.valid |=> !req.valid)
        else begin
            fail_count++;
            $error("req.valid high in two consecutive cycles");
        end

    // Bus released soon after the read strobe ends
    a_oe_release: assert property (@(posedge clk) disable iff (reset)
        $rose(rd_n) |-> ##5 !d_oe)
        else begin
            fail_count++;
            $error("d_oe still high 5 cycles after rd_n rose");
        end

endmodule

bind pwm_io_top pwm_io_checker #(
    .NUM_CHANNELS(NUM_CHANNELS)
) i_checker (
    .clk(clk),
    .reset(reset),
    .rd_n(rd_n),
    .d_oe(d_oe),
    .pwm_out(pwm_out),
    .req(req),
    .regs(regs),
    .fe_state(i_frontend.state)
);

// ==== testbench/pwm_io_tb.sv ====
module pwm_io_tb;

    import pwm_io_pkg::*;

    localparam int         NUM_CHANNELS    = 4;
    localparam logic [7:0] BASE_PORT       = 8'hE0;
    localparam int         STIM_DELAY      = 2;
    localparam int         NUM_TESTS       = 6;
    localparam int         WATCHDOG_CYCLES = NUM_TESTS * 3000 + 1000;

    logic                    clk;
    logic                    reset;
    logic [15:0]             a;
    logic [7:0]              d_in;
    logic [7:0]              d_out;
    logic                    d_oe;
    logic                    rd_n;
    logic                    wr_n;
    logic                    iorq_n;
    logic [NUM_CHANNELS-1:0] pwm_out;

    integer     seed = 32'h218a;
    logic [7:0] model_sample [NUM_CHANNELS];
    logic       model_enable [NUM_CHANNELS];

    pwm_io_top i_pwm_io_top (
        .clk(clk),
        .reset(reset),
        .a(a),
        .d_in(d_in),
        .d_out(d_out),
        .d_oe(d_oe),
        .rd_n(rd_n),
        .wr_n(wr_n),
        .iorq_n(iorq_n),
        .pwm_out(pwm_out)
    );

    always #10 clk = ~clk;

    ////////////////////////////////////////////////////////////
    // Reporting
    ////////////////////////////////////////////////////////////

    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("TESTBENCH FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [15:0] actual,
                               input logic [15:0] expected);
        if (actual !== expected) begin
            stop_with_failure($sformatf("FAILED %s: got 0x%0h, expected 0x%0h",
                                        name, actual, expected));
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Bus cycles
    ////////////////////////////////////////////////////////////

    // Port of a channel register is BASE_PORT + 2*chan + sel
    function automatic logic [7:0] port_of(input int ch, input reg_sel_e sel);
        return BASE_PORT + 8'(2 * ch) + {7'b0, sel};
    endfunction

    // Random high address byte that the block must ignore
    task automatic write_cycle(input logic [7:0] port, input logic [7:0] data,
                               input logic iorq_level);
        logic [31:0] rnd;
        rnd = $random(seed);
        @(posedge clk);
        #STIM_DELAY;
        a      = {rnd[7:0], port};
        d_in   = data;
        iorq_n = iorq_level;
        wr_n   = 1'b0;
        repeat (8) @(posedge clk);
        #STIM_DELAY;
        iorq_n = 1'b1;
        wr_n   = 1'b1;
        repeat (8) @(posedge clk);
    endtask

    task automatic io_write(input logic [7:0] port, input logic [7:0] data);
        write_cycle(port, data, 1'b0);
    endtask

    task automatic mem_write(input logic [7:0] port, input logic [7:0] data);
        write_cycle(port, data, 1'b1);
    endtask

    task automatic read_cycle(input logic [7:0] port, input logic decoded,
                              input logic [7:0] expected);
        logic [31:0] rnd;
        logic        seen;
        logic [7:0]  data;
        rnd  = $random(seed);
        seen = 1'b0;
        data = '0;
        @(posedge clk);
        #STIM_DELAY;
        a      = {rnd[7:0], port};
        iorq_n = 1'b0;
        rd_n   = 1'b0;
        repeat (8) begin
            @(negedge clk);
            if (!decoded) begin
                check_value("d_oe", 16'(d_oe), 16'h0);
            end else if (seen) begin
                // Data held for the rest of the read
                check_value("d_oe", 16'(d_oe), 16'h1);
                check_value("d_out", 16'(d_out), 16'(data));
            end else if (d_oe) begin
                seen = 1'b1;
                data = d_out;
            end
        end
        @(posedge clk);
        #STIM_DELAY;
        iorq_n = 1'b1;
        rd_n   = 1'b1;
        if (decoded && !seen) begin
            stop_with_failure($sformatf("d_oe never went high while reading port 0x%0h", port));
        end
        if (decoded) begin
            check_value($sformatf("d_out port 0x%0h", port), 16'(data), 16'(expected));
        end
        // Bus must be released within 5 cycles of the rising strobe
        for (int i = 1; i <= 8; i++) begin
            @(negedge clk);
            if (i >= 5 || !decoded) begin
                check_value("d_oe", 16'(d_oe), 16'h0);
            end
        end
    endtask

    task automatic io_read(input logic [7:0] port, input logic [7:0] expected);
        read_cycle(port, 1'b1, expected);
    endtask

    task automatic read_unmapped_port(input logic [7:0] port);
        read_cycle(port, 1'b0, 8'h00);
    endtask

    ////////////////////////////////////////////////////////////
    // Channel helpers
    ////////////////////////////////////////////////////////////

    task automatic write_channel(input int ch, input logic [7:0] sample,
                                 input logic [7:0] ctrl);
        io_write(port_of(ch, REG_SAMPLE), sample);
        io_write(port_of(ch, REG_CTRL), ctrl);
        model_sample[ch] = sample;
        model_enable[ch] = ctrl[0];
    endtask

    task automatic read_back_all();
        for (int ch = 0; ch < NUM_CHANNELS; ch++) begin
            io_read(port_of(ch, REG_SAMPLE), model_sample[ch]);
            io_read(port_of(ch, REG_CTRL), {7'b0, model_enable[ch]});
        end
    endtask

    // High cycles of every pwm_out bit over one 256 cycle window
    task automatic check_duty();
        logic [15:0] high_cnt [NUM_CHANNELS];
        for (int ch = 0; ch < NUM_CHANNELS; ch++) begin
            high_cnt[ch] = '0;
        end
        repeat (256) begin
            @(negedge clk);
            for (int ch = 0; ch < NUM_CHANNELS; ch++) begin
                if (pwm_out[ch]) begin
                    high_cnt[ch] = high_cnt[ch] + 16'd1;
                end
            end
        end
        for (int ch = 0; ch < NUM_CHANNELS; ch++) begin
            check_value($sformatf("pwm_out[%0d] high cycles", ch), high_cnt[ch],
                        model_enable[ch] ? 16'(model_sample[ch]) : 16'h0);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Directed tests
    ////////////////////////////////////////////////////////////

    task automatic test_reset_values();
        read_back_all();
        repeat (300) begin
            @(negedge clk);
            check_value("pwm_out", 16'(pwm_out), 16'h0);
        end
    endtask

    task automatic test_write_readback();
        logic [31:0] rnd;
        for (int ch = 0; ch < NUM_CHANNELS; ch++) begin
            rnd = $random(seed);
            // Upper control bits are junk and only bit 0 is kept
            write_channel(ch, rnd[7:0], rnd[15:8]);
        end
        read_back_all();
    endtask

    task automatic test_duty_cycle();
        logic [31:0] rnd;
        for (int ch = 0; ch < NUM_CHANNELS; ch++) begin
            rnd = $random(seed);
            if (ch == 0) begin
                write_channel(ch, 8'h00, 8'h01);
            end else if (ch == 1) begin
                write_channel(ch, 8'hFF, 8'h01);
            end else begin
                write_channel(ch, rnd[7:0], 8'h01);
            end
        end
        check_duty();
        // Second window at an unrelated offset
        rnd = $random(seed);
        repeat (int'(rnd[4:0])) @(posedge clk);
        check_duty();
    endtask

    task automatic test_enable_clear();
        logic [31:0] rnd;
        for (int ch = 0; ch < NUM_CHANNELS; ch++) begin
            rnd = $random(seed);
            write_channel(ch, rnd[7:0] | 8'h01, 8'h01);
        end
        check_duty();
        for (int ch = 0; ch < NUM_CHANNELS; ch++) begin
            io_write(port_of(ch, REG_CTRL), 8'h00);
            model_enable[ch] = 1'b0;
        end
        check_duty();
        read_back_all();
    endtask

    task automatic test_ignored_cycles();
        for (int ch = 0; ch < NUM_CHANNELS; ch++) begin
            mem_write(port_of(ch, REG_SAMPLE), ~model_sample[ch]);
            mem_write(port_of(ch, REG_CTRL), {7'b0, ~model_enable[ch]});
        end
        io_write(BASE_PORT + 8'd8, 8'h5A);
        io_write(BASE_PORT + 8'd9, 8'h01);
        read_back_all();
        read_unmapped_port(BASE_PORT + 8'd8);
        read_unmapped_port(BASE_PORT - 8'd1);
    endtask

    task automatic test_read_drive();
        for (int ch = 0; ch < NUM_CHANNELS; ch++) begin
            io_read(port_of(ch, REG_SAMPLE), model_sample[ch]);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Main sequence and watchdog
    ////////////////////////////////////////////////////////////

    initial begin
        clk    = 1'b0;
        reset  = 1'b1;
        a      = '0;
        d_in   = '0;
        rd_n   = 1'b1;
        wr_n   = 1'b1;
        iorq_n = 1'b1;
        for (int ch = 0; ch < NUM_CHANNELS; ch++) begin
            model_sample[ch] = '0;
            model_enable[ch] = 1'b0;
        end
        repeat (3) @(posedge clk);
        #STIM_DELAY;
        reset = 1'b0;

        test_reset_values();
        test_write_readback();
        test_duty_cycle();
        test_enable_clear();
        test_ignored_cycles();
        test_read_drive();

        if (i_pwm_io_top.i_checker.fail_count == 0) begin
            $display("TESTBENCH PASSED");
            $finish;
        end else begin
            stop_with_failure("Bus protocol assertions failed during the run");
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        stop_with_failure($sformatf("Timeout, tests still running after %0d cycles",
                                    WATCHDOG_CYCLES));
    end

endmodule
